// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_sublane_driver
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := SIMULATION PASSED

.PHONY: all compile run clean

all: run

# Build the simulation executable
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Run and fail unless the pass message shows up
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_sublane_driver.sv ====
`default_nettype none

module tb_sublane_driver;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS = 13;

    logic                  clk_i;
    logic                  rst_i;
    logic                  start_i;
    vlane_pkg::vl_t        vl_i;
    vlane_pkg::sew_e       sew_i;
    vlane_pkg::inst_type_e inst_type_i;
    vlane_pkg::delay_t     inst_delay_i;
    vlane_pkg::addr_t      vs1_start_i;
    vlane_pkg::addr_t      vs2_start_i;
    vlane_pkg::addr_t      vd_start_i;
    logic                  ready_o;
    logic                  vrf_ren_o;
    vlane_pkg::addr_t      vrf_raddr1_o;
    vlane_pkg::addr_t      vrf_raddr2_o;
    vlane_pkg::addr_t      vrf_waddr_o;
    vlane_pkg::bwen_t      vrf_bwen_o;
    logic                  store_data_valid_o;

    int          t_vl[NUM_TESTS];
    int          t_sew[NUM_TESTS];
    bit          t_store[NUM_TESTS];
    int          t_delay[NUM_TESTS];
    integer      seed;
    logic [31:0] rnd;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cyc_cnt = 0;
    int          cycle_limit = 100000;   // Replaced once the test list is known

    // Reference model state
    logic             busy;
    int               t;                 // Cycles since acceptance
    int               end_t;             // Cycle in which ready returns
    int               m_n;
    int               m_d;
    int               m_sh;
    logic             m_store;
    int               m_vs1;
    int               m_vs2;
    int               m_vd;
    vlane_pkg::addr_t last_ra1;
    vlane_pkg::addr_t last_ra2;
    vlane_pkg::addr_t last_wa;
    logic             exp_ready;
    logic             exp_ren;
    logic             exp_wr;
    logic             exp_sdv;
    vlane_pkg::addr_t exp_ra1;
    vlane_pkg::addr_t exp_ra2;
    vlane_pkg::addr_t exp_wa;
    vlane_pkg::bwen_t exp_bwen;

    sublane_driver sublane_driver_inst (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(start_i), .vl_i(vl_i), .sew_i(sew_i),
        .inst_type_i(inst_type_i), .inst_delay_i(inst_delay_i),
        .vs1_start_i(vs1_start_i), .vs2_start_i(vs2_start_i), .vd_start_i(vd_start_i),
        .ready_o(ready_o), .vrf_ren_o(vrf_ren_o), .vrf_raddr1_o(vrf_raddr1_o),
        .vrf_raddr2_o(vrf_raddr2_o), .vrf_waddr_o(vrf_waddr_o), .vrf_bwen_o(vrf_bwen_o),
        .store_data_valid_o(store_data_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    // Elements per lane, rounded up, never zero
    function automatic int lane_count(int vl);
        int n;
        n = (vl + vlane_pkg::VLANE_NUM - 1) / vlane_pkg::VLANE_NUM;
        return (n == 0) ? 1 : n;
    endfunction

    // log2 of elements per 4-byte location
    function automatic int elem_shift(vlane_pkg::sew_e sew);
        case (sew)
            vlane_pkg::SEW_BYTE: return 2;
            vlane_pkg::SEW_HALF: return 1;
            default:             return 0;
        endcase
    endfunction

    function automatic vlane_pkg::bwen_t expected_bwen(int sh, int k);
        case (sh)
            2:       return vlane_pkg::bwen_t'(4'b0001 << (k % 4));
            1:       return (k % 2 == 0) ? 4'b0011 : 4'b1100;
            default: return 4'b1111;
        endcase
    endfunction

    always_comb begin
        exp_ready = !(busy && t < end_t);
        exp_ren   = busy && t >= 2 && t <= 1 + m_n;
        exp_wr    = busy && !m_store && t >= 2 + m_d && t <= 1 + m_d + m_n;
        exp_sdv   = exp_ren && m_store;
        exp_ra1   = exp_ren ? vlane_pkg::addr_t'(m_vs1 + ((t - 2) >> m_sh)) : last_ra1;
        exp_ra2   = exp_ren ? vlane_pkg::addr_t'(m_vs2 + ((t - 2) >> m_sh)) : last_ra2;
        exp_wa    = exp_wr ? vlane_pkg::addr_t'(m_vd + ((t - 2 - m_d) >> m_sh)) : last_wa;
        exp_bwen  = exp_wr ? expected_bwen(m_sh, t - 2 - m_d) : '0;
    end

    always @(posedge clk_i) begin
        if (!rst_i) begin
            busy     <= 1'b0;
            t        <= 0;
            end_t    <= 0;
            last_ra1 <= '0;
            last_ra2 <= '0;
            last_wa  <= '0;
        end else begin
            if (exp_ren) begin
                last_ra1 <= exp_ra1;
                last_ra2 <= exp_ra2;
            end
            if (exp_wr) begin
                last_wa <= exp_wa;
            end
            if (start_i && exp_ready) begin
                busy    <= 1'b1;
                t       <= 1;
                m_n     <= lane_count(int'(vl_i));
                m_d     <= int'(inst_delay_i);
                m_sh    <= elem_shift(sew_i);
                m_store <= (inst_type_i == vlane_pkg::INST_STORE);
                m_vs1   <= int'(vs1_start_i);
                m_vs2   <= int'(vs2_start_i);
                m_vd    <= int'(vd_start_i);
                end_t   <= (inst_type_i == vlane_pkg::INST_STORE) ? 2 + lane_count(int'(vl_i))
                         : 2 + int'(inst_delay_i) + lane_count(int'(vl_i));
            end else if (busy && t < end_t) begin
                t <= t + 1;
            end else begin
                busy <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        errors++;
        $display("[FAIL] %s at cycle %0d: got 0x%0h, expected 0x%0h", name, cyc_cnt, got, exp);
    endtask

    a_ready: assert property (@(posedge clk_i) disable iff (!rst_i) ready_o == exp_ready)
        else report_mismatch("ready_o", $sampled(ready_o), $sampled(exp_ready));
    a_ren: assert property (@(posedge clk_i) disable iff (!rst_i) vrf_ren_o == exp_ren)
        else report_mismatch("vrf_ren_o", $sampled(vrf_ren_o), $sampled(exp_ren));
    a_sdv: assert property (@(posedge clk_i) disable iff (!rst_i) store_data_valid_o == exp_sdv)
        else report_mismatch("store_data_valid_o", $sampled(store_data_valid_o),
                             $sampled(exp_sdv));
    a_raddr1: assert property (@(posedge clk_i) disable iff (!rst_i) vrf_raddr1_o == exp_ra1)
        else report_mismatch("vrf_raddr1_o", $sampled(vrf_raddr1_o), $sampled(exp_ra1));
    a_raddr2: assert property (@(posedge clk_i) disable iff (!rst_i) vrf_raddr2_o == exp_ra2)
        else report_mismatch("vrf_raddr2_o", $sampled(vrf_raddr2_o), $sampled(exp_ra2));
    a_waddr: assert property (@(posedge clk_i) disable iff (!rst_i) vrf_waddr_o == exp_wa)
        else report_mismatch("vrf_waddr_o", $sampled(vrf_waddr_o), $sampled(exp_wa));
    a_bwen: assert property (@(posedge clk_i) disable iff (!rst_i) vrf_bwen_o == exp_bwen)
        else report_mismatch("vrf_bwen_o", $sampled(vrf_bwen_o), $sampled(exp_bwen));

    always @(posedge clk_i) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    task automatic set_test(int i, int vl, int sew, bit store, int delay);
        t_vl[i]    = vl;
        t_sew[i]   = sew;
        t_store[i] = store;
        t_delay[i] = delay;
    endtask

    task automatic run_test(int i);
        int err_before;
        err_before = errors;
        @(posedge clk_i);
        start_i      <= 1'b1;
        vl_i         <= vlane_pkg::vl_t'(t_vl[i]);
        sew_i        <= vlane_pkg::sew_e'(t_sew[i]);
        inst_type_i  <= t_store[i] ? vlane_pkg::INST_STORE : vlane_pkg::INST_NORMAL;
        inst_delay_i <= vlane_pkg::delay_t'(t_delay[i]);
        vs1_start_i  <= vlane_pkg::addr_t'($random(seed));
        vs2_start_i  <= vlane_pkg::addr_t'($random(seed));
        vd_start_i   <= vlane_pkg::addr_t'($random(seed));
        @(posedge clk_i);
        rnd = $random(seed);        // Start stays high into a busy cycle
        vl_i         <= vlane_pkg::vl_t'(rnd);
        inst_delay_i <= vlane_pkg::delay_t'(rnd[31:24]);
        @(posedge clk_i);
        start_i <= 1'b0;
        do @(negedge clk_i); while (!ready_o);
        @(negedge clk_i);           // Checks of the closing edge are in
        if (errors == err_before) tests_passed++;
        else tests_failed++;
        $display("test %0d: %s sew=%0d vl=%0d N=%0d delay=%0d -> %s", i,
                 t_store[i] ? "store " : "normal", t_sew[i], t_vl[i], lane_count(t_vl[i]),
                 t_delay[i], (errors == err_before) ? "ok" : "mismatches");
    endtask

    initial begin
        seed = 55672;
        set_test(0, 64, vlane_pkg::SEW_BYTE, 1'b0, 3);
        set_test(1, 37, vlane_pkg::SEW_HALF, 1'b0, 0);
        set_test(2, 0, vlane_pkg::SEW_WORD, 1'b0, 2);
        set_test(3, 24, vlane_pkg::SEW_BYTE, 1'b1, 5);
        set_test(4, 9, vlane_pkg::SEW_WORD, 1'b1, 0);
        set_test(5, 8, vlane_pkg::SEW_HALF, 1'b0, 12);
        set_test(6, 2000, vlane_pkg::SEW_BYTE, 1'b0, 7);   // Long run, addresses wrap
        for (int i = 7; i < NUM_TESTS; i++) begin
            rnd = $random(seed);
            set_test(i, int'(rnd[7:0]), int'(rnd[9:8]) % 3, rnd[12], int'(rnd[19:16]));
        end
        cycle_limit = 20;
        for (int i = 0; i < NUM_TESTS; i++) begin
            cycle_limit += 2 + t_delay[i] + lane_count(t_vl[i]) + 5;
        end

        rst_i        = 1'b0;
        start_i      = 1'b0;
        vl_i         = '0;
        sew_i        = vlane_pkg::SEW_BYTE;
        inst_type_i  = vlane_pkg::INST_NORMAL;
        inst_delay_i = '0;
        vs1_start_i  = '0;
        vs2_start_i  = '0;
        vd_start_i   = '0;
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b1;

        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
        end
        $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/vlane_pkg.sv
hw/inst_capture.sv
hw/lane_sequencer.sv
hw/vrf_addr_gen.sv
hw/byte_enable_gen.sv
hw/sublane_driver.sv
bench/tb_sublane_driver.sv

// ==== hw/byte_enable_gen.sv ====
`default_nettype none

module byte_enable_gen (
    input  wire                     clk_i,
    input  wire                     rst_i,
    input  wire                     load_i,
    input  wire                     wr_en_i,
    input  wire vlane_pkg::sew_e    sew_i,
    output vlane_pkg::bwen_t        bwen_o
);

    localparam int PHASE_W = $clog2(vlane_pkg::BYTES_PER_LOC);

    logic [PHASE_W - 1 : 0] phase_q;    // Element slot inside the location

    ////////////////////////////////////////
    // Phase counter
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            phase_q <= '0;
        end else if (load_i) begin
            phase_q <= '0;
        end else if (wr_en_i) begin
            phase_q <= phase_q + 1'b1;  // Wraps every location
        end
    end

    ////////////////////////////////////////
    // Enable map
    ////////////////////////////////////////
    always_comb begin
        bwen_o = '0;
        if (wr_en_i) begin
            case (sew_i)
                vlane_pkg::SEW_BYTE: begin
                    bwen_o = vlane_pkg::bwen_t'(1) << phase_q;
                end
                vlane_pkg::SEW_HALF: begin
                    // Even element low half, odd element high half
                    if (phase_q[0]) begin
                        bwen_o = vlane_pkg::bwen_t'(4'b1100);
                    end else begin
                        bwen_o = vlane_pkg::bwen_t'(4'b0011);
                    end
                end
                vlane_pkg::SEW_WORD: bwen_o = '1;
                default:             bwen_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/inst_capture.sv ====
`default_nettype none

module inst_capture (
    input  wire                         clk_i,
    input  wire                         rst_i,
    input  wire                         start_i,
    input  wire vlane_pkg::vl_t         vl_i,
    input  wire vlane_pkg::sew_e        sew_i,
    input  wire vlane_pkg::inst_type_e  inst_type_i,
    input  wire vlane_pkg::delay_t      inst_delay_i,
    input  wire vlane_pkg::addr_t       vs1_start_i,
    input  wire vlane_pkg::addr_t       vs2_start_i,
    input  wire vlane_pkg::addr_t       vd_start_i,
    input  wire                         done_i,
    output logic                        ready_o,
    output logic                        cmd_valid_o,
    output vlane_pkg::sew_e             sew_o,
    output vlane_pkg::inst_type_e       inst_type_o,
    output vlane_pkg::delay_t           inst_delay_o,
    output vlane_pkg::addr_t            vs1_start_o,
    output vlane_pkg::addr_t            vs2_start_o,
    output vlane_pkg::addr_t            vd_start_o,
    output vlane_pkg::elem_cnt_t        elem_cnt_o
);

    localparam int LANE_SHIFT = $clog2(vlane_pkg::VLANE_NUM);

    logic                 accept;
    vlane_pkg::elem_cnt_t lane_cnt;     // Elements landing in this lane

    assign accept = start_i && ready_o;

    // ceil(vl / VLANE_NUM), at least one
    always_comb begin
        lane_cnt = vlane_pkg::elem_cnt_t'(vl_i >> LANE_SHIFT);
        if (vl_i[LANE_SHIFT - 1 : 0] != '0) begin
            lane_cnt = lane_cnt + 1'b1;
        end
        if (lane_cnt == '0) begin
            lane_cnt = vlane_pkg::elem_cnt_t'(1);   // Empty vl still runs one element
        end
    end

    ////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            ready_o     <= 1'b1;
            cmd_valid_o <= 1'b0;
        end else begin
            cmd_valid_o <= accept;          // One-cycle pulse
            if (accept) begin
                ready_o <= 1'b0;
            end else if (done_i) begin
                ready_o <= 1'b1;
            end
        end
    end

    // Instruction register
    always_ff @(posedge clk_i) begin
        if (accept) begin
            sew_o        <= sew_i;
            inst_type_o  <= inst_type_i;
            inst_delay_o <= inst_delay_i;
            vs1_start_o  <= vs1_start_i;
            vs2_start_o  <= vs2_start_i;
            vd_start_o   <= vd_start_i;
            elem_cnt_o   <= lane_cnt;
        end
    end

    // Sequencer may only finish an instruction that was accepted here
    a_done_only_when_busy: assert property (@(posedge clk_i) disable iff (!rst_i)
        done_i |-> !ready_o);

endmodule

`default_nettype wire

// ==== hw/lane_sequencer.sv ====
`default_nettype none

module lane_sequencer (
    input  wire                         clk_i,
    input  wire                         rst_i,
    input  wire                         cmd_valid_i,
    input  wire vlane_pkg::inst_type_e  inst_type_i,
    input  wire vlane_pkg::delay_t      inst_delay_i,
    input  wire vlane_pkg::elem_cnt_t   elem_cnt_i,
    output logic                        addr_load_o,
    output logic                        rd_en_o,
    output logic                        wr_en_o,
    output logic                        done_o
);

    typedef enum logic [1 : 0] {
        SEQ_IDLE,
        SEQ_RUN,        // Reads, then writes after the delay
        SEQ_STORE       // Reads only
    } seq_state_e;

    // Headroom for delay plus count
    typedef logic [$bits(vlane_pkg::elem_cnt_t) : 0] win_t;

    seq_state_e           state_q;
    seq_state_e           state_d;
    vlane_pkg::elem_cnt_t cnt_q;        // Cycles since the window opened
    win_t                 cnt_ext;
    win_t                 rd_end;
    win_t                 wr_first;
    win_t                 wr_end;

    assign cnt_ext  = win_t'(cnt_q);
    assign rd_end   = win_t'(elem_cnt_i);
    assign wr_first = win_t'(inst_delay_i);
    assign wr_end   = wr_first + rd_end;

    ////////////////////////////////////////
    // Window decode
    ////////////////////////////////////////
    assign addr_load_o = (state_q == SEQ_IDLE);     // Generators rewind while idle
    assign rd_en_o     = (state_q != SEQ_IDLE) && (cnt_ext < rd_end);
    assign wr_en_o     = (state_q == SEQ_RUN) && (cnt_ext >= wr_first) && (cnt_ext < wr_end);

    // Last active cycle of the instruction
    always_comb begin
        case (state_q)
            SEQ_RUN:   done_o = (cnt_ext == wr_end - 1'b1);
            SEQ_STORE: done_o = (cnt_ext == rd_end - 1'b1);
            default:   done_o = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            SEQ_IDLE: begin
                if (cmd_valid_i) begin
                    if (inst_type_i == vlane_pkg::INST_STORE) begin
                        state_d = SEQ_STORE;
                    end else begin
                        state_d = SEQ_RUN;
                    end
                end
            end
            SEQ_RUN, SEQ_STORE: begin
                if (done_o) begin
                    state_d = SEQ_IDLE;
                end
            end
            default: state_d = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= SEQ_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == SEQ_IDLE) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // Command pulse only arrives between instructions
    a_cmd_in_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
        cmd_valid_i |-> (state_q == SEQ_IDLE));

    // Instruction fields hold still while the windows run
    a_operands_stable: assert property (@(posedge clk_i) disable iff (!rst_i)
        (state_q != SEQ_IDLE) |-> $stable(elem_cnt_i) && $stable(inst_delay_i)
            && $stable(inst_type_i));

endmodule

`default_nettype wire

// ==== hw/sublane_driver.sv ====
`default_nettype none

module sublane_driver (
    input  wire                         clk_i,
    input  wire                         rst_i,
    input  wire                         start_i,
    input  wire vlane_pkg::vl_t         vl_i,
    input  wire vlane_pkg::sew_e        sew_i,
    input  wire vlane_pkg::inst_type_e  inst_type_i,
    input  wire vlane_pkg::delay_t      inst_delay_i,
    input  wire vlane_pkg::addr_t       vs1_start_i,
    input  wire vlane_pkg::addr_t       vs2_start_i,
    input  wire vlane_pkg::addr_t       vd_start_i,
    output logic                        ready_o,
    output logic                        vrf_ren_o,
    output vlane_pkg::addr_t            vrf_raddr1_o,
    output vlane_pkg::addr_t            vrf_raddr2_o,
    output vlane_pkg::addr_t            vrf_waddr_o,
    output vlane_pkg::bwen_t            vrf_bwen_o,
    output logic                        store_data_valid_o
);

    logic                  cmd_valid;
    vlane_pkg::sew_e       sew;
    vlane_pkg::inst_type_e inst_type;
    vlane_pkg::delay_t     inst_delay;
    vlane_pkg::addr_t      vs1_start;
    vlane_pkg::addr_t      vs2_start;
    vlane_pkg::addr_t      vd_start;
    vlane_pkg::elem_cnt_t  elem_cnt;
    logic                  addr_load;
    logic                  rd_en;
    logic                  wr_en;
    logic                  done;

    ////////////////////////////////////////
    // Control path
    ////////////////////////////////////////
    inst_capture inst_capture_inst (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(start_i),
        .vl_i(vl_i), .sew_i(sew_i), .inst_type_i(inst_type_i),
        .inst_delay_i(inst_delay_i),
        .vs1_start_i(vs1_start_i), .vs2_start_i(vs2_start_i), .vd_start_i(vd_start_i),
        .done_i(done), .ready_o(ready_o), .cmd_valid_o(cmd_valid),
        .sew_o(sew), .inst_type_o(inst_type), .inst_delay_o(inst_delay),
        .vs1_start_o(vs1_start), .vs2_start_o(vs2_start), .vd_start_o(vd_start),
        .elem_cnt_o(elem_cnt)
    );

    lane_sequencer lane_sequencer_inst (
        .clk_i(clk_i), .rst_i(rst_i), .cmd_valid_i(cmd_valid),
        .inst_type_i(inst_type), .inst_delay_i(inst_delay), .elem_cnt_i(elem_cnt),
        .addr_load_o(addr_load), .rd_en_o(rd_en), .wr_en_o(wr_en), .done_o(done)
    );

    ////////////////////////////////////////
    // VRF side
    ////////////////////////////////////////
    vrf_addr_gen raddr1_gen (   // vs1 operand
        .clk_i(clk_i), .rst_i(rst_i), .load_i(addr_load), .en_i(rd_en),
        .sew_i(sew), .start_addr_i(vs1_start), .addr_o(vrf_raddr1_o)
    );

    vrf_addr_gen raddr2_gen (   // vs2 operand
        .clk_i(clk_i), .rst_i(rst_i), .load_i(addr_load), .en_i(rd_en),
        .sew_i(sew), .start_addr_i(vs2_start), .addr_o(vrf_raddr2_o)
    );

    vrf_addr_gen waddr_gen (
        .clk_i(clk_i), .rst_i(rst_i), .load_i(addr_load), .en_i(wr_en),
        .sew_i(sew), .start_addr_i(vd_start), .addr_o(vrf_waddr_o)
    );

    byte_enable_gen byte_enable_gen_inst (
        .clk_i(clk_i), .rst_i(rst_i), .load_i(addr_load), .wr_en_i(wr_en),
        .sew_i(sew), .bwen_o(vrf_bwen_o)
    );

    assign vrf_ren_o          = rd_en;
    assign store_data_valid_o = rd_en && (inst_type == vlane_pkg::INST_STORE);

endmodule

`default_nettype wire

// ==== hw/vlane_pkg.sv ====
`default_nettype none

package vlane_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////
    localparam int VLANE_NUM       = 8;
    localparam int MAX_VL_PER_LANE = 256;     // Elements held by one lane
    localparam int MEM_DEPTH       = 512;     // Locations in one lane VRF
    localparam int BYTES_PER_LOC   = 4;

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////
    // Total vector length over all lanes
    typedef logic [$clog2(VLANE_NUM * MAX_VL_PER_LANE) - 1 : 0] vl_t;

    // One extra bit so a full lane count fits
    typedef logic [$clog2(MAX_VL_PER_LANE) : 0] elem_cnt_t;

    typedef logic [$clog2(MAX_VL_PER_LANE) - 1 : 0] delay_t;   // Read to write distance
    typedef logic [$clog2(MEM_DEPTH) - 1 : 0]       addr_t;
    typedef logic [BYTES_PER_LOC - 1 : 0]           bwen_t;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////
    typedef enum logic [1 : 0] {
        SEW_BYTE = 2'd0,    // 4 elements per location
        SEW_HALF = 2'd1,    // 2 elements per location
        SEW_WORD = 2'd2     // 1 element per location
    } sew_e;

    typedef enum logic {
        INST_NORMAL = 1'b0,
        INST_STORE  = 1'b1
    } inst_type_e;

endpackage

`default_nettype wire

// ==== hw/vrf_addr_gen.sv ====
`default_nettype none

module vrf_addr_gen (
    input  wire                     clk_i,
    input  wire                     rst_i,
    input  wire                     load_i,
    input  wire                     en_i,
    input  wire vlane_pkg::sew_e    sew_i,
    input  wire vlane_pkg::addr_t   start_addr_i,
    output vlane_pkg::addr_t        addr_o
);

    vlane_pkg::addr_t     base_q;
    vlane_pkg::addr_t     last_q;       // Address of the latest access
    vlane_pkg::elem_cnt_t idx_q;        // Element index within the instruction
    vlane_pkg::elem_cnt_t loc_off;
    vlane_pkg::addr_t     step_addr;

    // Elements per location set the shift
    always_comb begin
        case (sew_i)
            vlane_pkg::SEW_BYTE: loc_off = idx_q >> 2;
            vlane_pkg::SEW_HALF: loc_off = idx_q >> 1;
            default:             loc_off = idx_q;
        endcase
    end

    assign step_addr = base_q + vlane_pkg::addr_t'(loc_off);
    assign addr_o    = en_i ? step_addr : last_q;   // Hold between windows

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            base_q <= start_addr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            idx_q  <= '0;
            last_q <= '0;
        end else if (load_i) begin
            idx_q <= '0;
        end else if (en_i) begin
            idx_q  <= idx_q + 1'b1;
            last_q <= step_addr;
        end
    end

    // Rewind and stepping come from different sequencer states
    a_no_load_while_stepping: assert property (@(posedge clk_i) disable iff (!rst_i)
        !(load_i && en_i));

endmodule

`default_nettype wire
